/* vlog.f */
source/scope_pkg.sv
source/scope_regs.sv
source/scope_decimator.sv
source/scope_edge.sv
source/scope_acq.sv
source/scope_top.sv
sim/scope_tb.sv

/* Bender.yml */
package:
  name: scope_channel

sources:
  # rtl, package first
  - files:
      - source/scope_pkg.sv
      - source/scope_regs.sv
      - source/scope_decimator.sv
      - source/scope_edge.sv
      - source/scope_acq.sv
      - source/scope_top.sv

  # testbench
  - target: simulation
    files:
      - sim/scope_tb.sv

/* sim/scope_tb.sv */
/*
 * scope channel testbench
 * axi4-lite master tasks, adc ramp, stream collector and directed tests
 */
`timescale 1ns/1ps

module scope_tb import scope_pkg::*; ();

  // cycle budget per test, run limit is 4x the sum
  localparam int BUDGET_REGS    = 400;
  localparam int BUDGET_DEC     = 300;
  localparam int BUDGET_AVG     = 300;
  localparam int BUDGET_EDGE    = 500;
  localparam int BUDGET_PRE     = 300;
  localparam int BUDGET_STOP    = 300;
  localparam int TIMEOUT_CYCLES = 4 * (BUDGET_REGS + BUDGET_DEC + BUDGET_AVG +
                                       BUDGET_EDGE + BUDGET_PRE + BUDGET_STOP);
  localparam int PARK_LVL       = 8191;  // edge level the ramp never reaches

  logic       bus, rst_n;
  reg_addr_t  s_awaddr, s_araddr;
  reg_data_t  s_wdata, s_rdata;
  logic [3:0] s_wstrb;
  logic [1:0] s_bresp, s_rresp;
  logic       s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic       s_arvalid, s_arready, s_rvalid, s_rready;
  logic       adc_valid;
  sample_t    adc_data;
  logic       sto_valid, sto_last, trg_out, irq_trg, irq_stp;
  sample_t    sto_data;

  logic    adc_run;       // ramp enable
  sample_t ramp_val;      // next ramp value
  int      adc_log[$];    // every sample driven since last clear
  int      out_data[$];   // collected stream
  logic    out_last[$];
  int      n_irq_trg, n_irq_stp, n_trg_out;
  int      trg_idx;       // index of first sample after the trigger sample
  int      errors, checks, n_tests, test_err0, cycles;

  scope_top scope_top_i (
    .bus, .rst_n,
    .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready,
    .s_araddr, .s_arvalid, .s_arready, .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .adc_valid, .adc_data,
    .sto_valid, .sto_data, .sto_last,
    .trg_out, .irq_trg, .irq_stp
  );

  always #4 bus = ~bus;  // 8 ns period

  //////////////////////////////////////////////////
  // ramp source, collector, watchdog
  //////////////////////////////////////////////////

  always @(posedge bus) begin
    #1;
    adc_valid = adc_run;
    if (adc_run) begin
      adc_data = ramp_val;
      adc_log.push_back(int'(ramp_val));
      ramp_val = ramp_val + 1'b1;  // +1 per valid sample
    end
  end

  // outputs settle after the rising edge, sampled mid cycle
  always @(negedge bus) begin
    if (sto_valid) begin
      out_data.push_back(int'(sto_data));
      out_last.push_back(sto_last);
    end
    if (irq_trg) begin
      n_irq_trg++;
      trg_idx = out_data.size();  // trigger sample already pushed
    end
    if (irq_stp) n_irq_stp++;
    if (trg_out) n_trg_out++;
  end

  always @(posedge bus) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("TIMEOUT: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic axi_write(input reg_addr_t addr, input reg_data_t data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int stall;
    @(posedge bus);
    #1;
    s_awaddr  = addr;
    s_wdata   = data;
    s_wstrb   = strb;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    @(negedge bus);
    while (!(s_awready && s_wready)) @(negedge bus);
    @(posedge bus);   // aw and w taken here
    #1;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    @(negedge bus);
    while (!s_bvalid) @(negedge bus);
    stall = $urandom_range(3, 0);  // back-pressure on b
    repeat (stall) @(posedge bus);
    @(posedge bus);
    #1;
    s_bready = 1'b1;
    @(negedge bus);
    resp = s_bresp;
    @(posedge bus);
    #1;
    s_bready = 1'b0;
  endtask

  task automatic axi_read(input reg_addr_t addr, output reg_data_t data,
                          output logic [1:0] resp);
    int stall;
    @(posedge bus);
    #1;
    s_araddr  = addr;
    s_arvalid = 1'b1;
    @(negedge bus);
    while (!s_arready) @(negedge bus);
    @(posedge bus);
    #1;
    s_arvalid = 1'b0;
    @(negedge bus);
    while (!s_rvalid) @(negedge bus);
    stall = $urandom_range(3, 0);  // rdata must hold meanwhile
    repeat (stall) @(posedge bus);
    @(posedge bus);
    #1;
    s_rready = 1'b1;
    @(negedge bus);
    data = s_rdata;
    resp = s_rresp;
    @(posedge bus);
    #1;
    s_rready = 1'b0;
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    logic [1:0] resp;
    axi_write(addr, data, 4'hf, resp);
    check($sformatf("bresp @%02h", addr), resp, RESP_OKAY);
  endtask

  task automatic write_read(input reg_addr_t addr, input reg_data_t wdata,
                            input reg_data_t exp);
    reg_data_t  rdata;
    logic [1:0] resp;
    write_reg(addr, wdata);
    axi_read(addr, rdata, resp);
    check($sformatf("rresp @%02h", addr), resp, RESP_OKAY);
    check($sformatf("rdata @%02h", addr), rdata, exp);
  endtask

  task automatic start_adc();
    @(negedge bus);
    adc_run = 1'b1;
  endtask

  task automatic stop_adc();
    @(negedge bus);
    adc_run = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge bus);
  endtask

  // adc must be stopped, ctl reset restarts groups, edge and fsm
  task automatic configure(input logic avg, input int dec, input int shr, input int pre,
                           input int pst, input int lvl, input int hst, input logic edg);
    write_reg(REG_AVG, reg_data_t'(avg));
    write_reg(REG_DEC, dec);
    write_reg(REG_SHR, shr);
    write_reg(REG_PRE, pre);
    write_reg(REG_PST, pst);
    write_reg(REG_LVL, lvl);
    write_reg(REG_HST, hst);
    write_reg(REG_EDG, reg_data_t'(edg));
    write_reg(REG_CTL, 32'h1);
    @(posedge bus);  // collector only writes on the falling edge
    adc_log.delete();
    out_data.delete();
    out_last.delete();
    n_irq_trg = 0;
    n_irq_stp = 0;
    n_trg_out = 0;
    trg_idx   = 0;
  endtask

  task automatic wait_stops(input int n, input int limit);
    int waited = 0;
    while (n_irq_stp < n && waited < limit) begin
      @(posedge bus);
      waited++;
    end
    if (n_irq_stp < n) begin
      errors++;
      $display("ERROR at %0d ns: no stop interrupt within %0d cycles", $time, limit);
    end
  endtask

  task automatic wait_samples(input int n, input int limit);
    int waited = 0;
    while (out_data.size() < n && waited < limit) begin
      @(posedge bus);
      waited++;
    end
    if (out_data.size() < n) begin
      errors++;
      $display("ERROR at %0d ns: only %0d of %0d stream samples arrived", $time,
               out_data.size(), n);
    end
  endtask

  task automatic begin_test();
    test_err0 = errors;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("test %-12s %s", name, (errors == test_err0) ? "passed" : "FAILED");
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_registers();
    reg_data_t  rdata;
    logic [1:0] resp;
    begin_test();
    check("stream and irq after reset", {sto_valid, sto_last, irq_trg, irq_stp, trg_out}, 0);
    check("axi ready/valid after reset",
          {s_awready, s_wready, s_arready, s_bvalid, s_rvalid}, 0);
    write_read(REG_PRE, 32'h1234_5678, 32'h1234_5678);
    axi_write(REG_PRE, 32'haabb_ccdd, 4'b0010, resp);  // byte lane 1 only
    check("bresp strobe write", resp, RESP_OKAY);
    axi_read(REG_PRE, rdata, resp);
    check("rdata pre after strobe", rdata, 32'h1234_cc78);
    write_read(REG_PST, 32'h0000_0040, 32'h0000_0040);
    write_read(REG_LVL, 32'hffff_f000, 32'hffff_f000);  // -4096
    write_read(REG_LVL, 32'h0000_3123, 32'hffff_f123);  // bit 13 is the sign
    write_read(REG_HST, 32'h0000_0007, 32'h0000_0007);
    write_read(REG_EDG, 32'hffff_ffff, 32'h0000_0001);
    write_read(REG_AVG, 32'h0000_0001, 32'h0000_0001);
    write_read(REG_DEC, 32'hfff1_0005, 32'h0001_0005);  // 17 bit factor
    write_read(REG_SHR, 32'h0000_00f3, 32'h0000_0003);
    axi_read(7'h40, rdata, resp);  // hole in the map
    check("rresp unmapped", resp, RESP_SLVERR);
    check("rdata unmapped", rdata, 0);
    axi_write(REG_STS, 32'h3, 4'hf, resp);
    check("bresp write to sts", resp, RESP_SLVERR);
    end_test("registers");
  endtask

  task automatic test_decimation();
    begin_test();
    configure(1'b0, 4, 0, 0, 8, PARK_LVL, 0, 1'b0);
    write_reg(REG_CTL, 32'h4);  // start
    write_reg(REG_CTL, 32'h2);  // sw trigger, held for first sample
    start_adc();
    wait_stops(1, 200);
    idle(16);
    stop_adc();
    check("samples after trigger", out_data.size() - trg_idx, 8);
    check("irq_trg pulses", n_irq_trg, 1);
    check("irq_stp pulses", n_irq_stp, 1);
    for (int k = 0; k < out_data.size(); k++) begin
      check($sformatf("sto_data[%0d]", k), out_data[k], adc_log[4*k+3]);  // last of group
      check($sformatf("sto_last[%0d]", k), out_last[k], k == out_data.size() - 1);
      if (k > 0) check($sformatf("step[%0d]", k), out_data[k] - out_data[k-1], 4);
    end
    end_test("decimation");
  endtask

  task automatic test_averaging();
    int sum;
    begin_test();
    configure(1'b1, 4, 2, 0, 4, PARK_LVL, 0, 1'b0);
    write_reg(REG_CTL, 32'h4);
    write_reg(REG_CTL, 32'h2);
    start_adc();
    wait_stops(1, 200);
    idle(16);
    stop_adc();
    check("averaged samples", out_data.size(), 5);  // trigger sample + 4 post
    for (int k = 0; k < out_data.size(); k++) begin
      sum = adc_log[4*k] + adc_log[4*k+1] + adc_log[4*k+2] + adc_log[4*k+3];
      check($sformatf("avg[%0d]", k), out_data[k], sum >>> 2);  // mean, floor
      if (k > 0) check($sformatf("avg step[%0d]", k), out_data[k] - out_data[k-1], 4);
    end
    end_test("averaging");
  endtask

  task automatic test_edge_trigger();
    int lvl;
    begin_test();
    lvl = int'(ramp_val) + 40;  // inside the coming ramp
    configure(1'b0, 1, 0, 0, 4, lvl, 5, 1'b0);
    write_reg(REG_CTL, 32'h4);
    start_adc();
    wait_stops(1, 200);
    idle(8);
    stop_adc();
    check("trg_out pulses", n_trg_out, 1);
    check("irq_trg pulses", n_irq_trg, 1);
    check("post samples present", out_data.size() > trg_idx, 1);
    check("first post sample >= level", out_data[trg_idx] >= lvl, 1);
    // falling edge setting on a rising ramp
    lvl = int'(ramp_val) + 40;
    configure(1'b0, 1, 0, 0, 4, lvl, 5, 1'b1);
    write_reg(REG_CTL, 32'h4);
    start_adc();
    idle(80);
    stop_adc();
    check("trg_out on neg edge", n_trg_out, 0);
    check("irq_trg on neg edge", n_irq_trg, 0);
    end_test("edge");
  endtask

  task automatic test_pre_gating();
    begin_test();
    configure(1'b0, 4, 0, 6, 4, PARK_LVL, 0, 1'b0);
    write_reg(REG_CTL, 32'h4);
    write_reg(REG_CTL, 32'h2);  // too early, still pre
    start_adc();
    wait_samples(8, 100);  // a trigger latched in pre would have fired by now
    check("early trigger ignored", n_irq_trg, 0);
    write_reg(REG_CTL, 32'h2);
    wait_stops(1, 200);
    idle(16);
    stop_adc();
    check("irq_trg pulses", n_irq_trg, 1);
    check("pre samples before trigger >= 6", trg_idx - 1 >= 6, 1);
    check("samples after trigger", out_data.size() - trg_idx, 4);
    end_test("pre gating");
  endtask

  task automatic test_stop();
    reg_data_t  rdata;
    logic [1:0] resp;
    int         n_seen;
    begin_test();
    configure(1'b0, 1, 0, 0, 100, PARK_LVL, 0, 1'b0);
    write_reg(REG_CTL, 32'h4);
    write_reg(REG_CTL, 32'h2);
    start_adc();
    wait_samples(20, 100);
    write_reg(REG_CTL, 32'h8);  // stop mid post
    wait_stops(1, 50);
    n_seen = out_data.size();
    idle(10);
    stop_adc();
    check("no samples after stop", out_data.size(), n_seen);
    check("irq_stp pulses", n_irq_stp, 1);
    check("last flag on final sample", out_last[out_data.size() - 1], 1);
    axi_read(REG_STS, rdata, resp);
    check("sts acquiring", rdata[0], 0);
    axi_read(REG_STS_PST, rdata, resp);
    check("sts_pst below pst", rdata < 100, 1);
    check("sts_pst counted", rdata > 0, 1);
    end_test("stop");
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'haddb_24bd));
    bus       = 1'b0;
    rst_n     = 1'b0;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    adc_valid = 1'b0;
    adc_data  = '0;
    adc_run   = 1'b0;
    ramp_val  = 14'sd100;
    repeat (8) @(posedge bus);
    #1;
    rst_n = 1'b1;
    test_registers();
    test_decimation();
    test_averaging();
    test_edge_trigger();
    test_pre_gating();
    test_stop();
    $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : scope_tb

/* source/scope_top.sv */
/*
 * scope channel top
 * register block, decimator, edge detector and acquisition controller
 */
`timescale 1ns/1ps

module scope_top import scope_pkg::*; (
  input  logic       bus,
  input  logic       rst_n,
  // axi4-lite slave
  input  reg_addr_t  s_awaddr,
  input  logic       s_awvalid,
  output logic       s_awready,
  input  reg_data_t  s_wdata,
  input  logic [3:0] s_wstrb,
  input  logic       s_wvalid,
  output logic       s_wready,
  output logic [1:0] s_bresp,
  output logic       s_bvalid,
  input  logic       s_bready,
  input  reg_addr_t  s_araddr,
  input  logic       s_arvalid,
  output logic       s_arready,
  output reg_data_t  s_rdata,
  output logic [1:0] s_rresp,
  output logic       s_rvalid,
  input  logic       s_rready,
  // adc stream, never stalled
  input  logic       adc_valid,
  input  sample_t    adc_data,
  // output stream
  output logic       sto_valid,
  output sample_t    sto_data,
  output logic       sto_last,
  // triggers and interrupts
  output logic       trg_out,
  output logic       irq_trg,
  output logic       irq_stp
);

  //////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////

  logic    ctl_rst, ctl_trg, ctl_acq, ctl_stp;
  cnt_t    cfg_pre, cfg_pst;
  sample_t cfg_lvl, cfg_hst;
  logic    cfg_edg, cfg_avg;
  dec_t    cfg_dec;
  shr_t    cfg_shr;
  logic    sts_acq, sts_trg;
  cnt_t    sts_pre, sts_pst;
  logic    dec_valid;
  sample_t dec_data;

  scope_regs regs_i (
    .bus, .rst_n,
    .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready,
    .s_araddr, .s_arvalid, .s_arready, .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst,
    .ctl_rst, .ctl_trg, .ctl_acq, .ctl_stp,
    .cfg_pre, .cfg_pst, .cfg_lvl, .cfg_hst, .cfg_edg,
    .cfg_avg, .cfg_dec, .cfg_shr
  );

  scope_decimator dec_i (
    .bus, .rst_n, .ctl_rst,
    .cfg_avg, .cfg_dec, .cfg_shr,
    .adc_valid, .adc_data,
    .dec_valid, .dec_data
  );

  // edge detector watches raw samples
  scope_edge edge_i (
    .bus, .rst_n, .ctl_rst,
    .cfg_lvl, .cfg_hst, .cfg_edg,
    .adc_valid, .adc_data,
    .edge_trg (trg_out)
  );

  scope_acq acq_i (
    .bus, .rst_n,
    .ctl_rst, .ctl_acq, .ctl_stp, .ctl_trg,
    .edge_trg (trg_out),
    .cfg_pre, .cfg_pst,
    .dec_valid, .dec_data,
    .sto_valid, .sto_data, .sto_last,
    .irq_trg, .irq_stp,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst
  );

endmodule : scope_top

/* source/scope_acq.sv */
/*
 * scope acquisition controller
 * pre/post trigger fsm, gates decimated stream and raises interrupts
 */
`timescale 1ns/1ps

module scope_acq import scope_pkg::*; (
  input  logic    bus,
  input  logic    rst_n,
  input  logic    ctl_rst,
  input  logic    ctl_acq,    // start
  input  logic    ctl_stp,    // stop
  input  logic    ctl_trg,    // software trigger
  input  logic    edge_trg,   // edge detector trigger
  input  cnt_t    cfg_pre,
  input  cnt_t    cfg_pst,
  input  logic    dec_valid,
  input  sample_t dec_data,
  output logic    sto_valid,
  output sample_t sto_data,
  output logic    sto_last,
  output logic    irq_trg,
  output logic    irq_stp,
  output logic    sts_acq,
  output logic    sts_trg,
  output cnt_t    sts_pre,
  output cnt_t    sts_pst
);

  acq_state_t state;
  logic trg_in;    // any trigger this cycle
  logic trg_pend;  // trigger waiting for next sample
  cnt_t pre_nxt;
  cnt_t pst_nxt;

  assign trg_in  = edge_trg || ctl_trg;
  assign pre_nxt = sts_pre + cnt_t'(1);
  assign pst_nxt = sts_pst + cnt_t'(1);
  assign sts_acq = (state != ACQ_IDLE);

  //////////////////////////////////////////////////
  // acquisition fsm
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      state     <= ACQ_IDLE;
      trg_pend  <= 1'b0;
      sts_trg   <= 1'b0;
      sts_pre   <= '0;
      sts_pst   <= '0;
      sto_valid <= 1'b0;
      sto_last  <= 1'b0;
      irq_trg   <= 1'b0;
      irq_stp   <= 1'b0;
    end else begin
      sto_valid <= 1'b0;
      sto_last  <= 1'b0;
      irq_trg   <= 1'b0;
      irq_stp   <= 1'b0;
      if (ctl_rst) begin
        state    <= ACQ_IDLE;  // abort, no interrupt
        trg_pend <= 1'b0;
        sts_trg  <= 1'b0;
      end else if (ctl_stp && state != ACQ_IDLE) begin
        state     <= ACQ_IDLE;
        trg_pend  <= 1'b0;
        sto_valid <= dec_valid;  // sample in flight closes the stream
        sto_last  <= dec_valid;
        irq_stp   <= 1'b1;
      end else begin
        if (state != ACQ_IDLE) sto_valid <= dec_valid;
        case (state)
          ACQ_IDLE: if (ctl_acq) begin
            state    <= ACQ_PRE;
            sts_pre  <= '0;
            sts_pst  <= '0;
            sts_trg  <= 1'b0;
            trg_pend <= 1'b0;
          end
          ACQ_PRE: begin
            // triggers ignored here
            if (dec_valid) begin
              sts_pre <= pre_nxt;
              if (pre_nxt >= cfg_pre) state <= ACQ_ARMED;
            end else if (sts_pre >= cfg_pre) begin
              state <= ACQ_ARMED;  // zero pre count
            end
          end
          ACQ_ARMED: begin
            if (dec_valid) begin
              sts_pre <= pre_nxt;
              if (trg_in || trg_pend) begin
                state    <= ACQ_POST;
                trg_pend <= 1'b0;
                sts_trg  <= 1'b1;
                irq_trg  <= 1'b1;
              end
            end else if (trg_in) begin
              trg_pend <= 1'b1;  // hold until next sample
            end
          end
          ACQ_POST: if (dec_valid) begin
            sts_pst <= pst_nxt;
            if (pst_nxt >= cfg_pst) begin
              state    <= ACQ_IDLE;
              sto_last <= 1'b1;
              irq_stp  <= 1'b1;
            end
          end
          default: state <= ACQ_IDLE;
        endcase
      end
    end
  end

  // stream payload
  always_ff @(posedge bus) begin
    if (dec_valid) sto_data <= dec_data;
  end

  // output sample comes from a cycle spent acquiring
  a_sto_gate: assert property (@(posedge bus) disable iff (!rst_n)
    sto_valid |-> $past(state) != ACQ_IDLE);

endmodule : scope_acq

/* source/scope_edge.sv */
/*
 * scope edge detector
 * schmitt trigger on raw samples, level plus hysteresis, edge select
 */
`timescale 1ns/1ps

module scope_edge import scope_pkg::*; (
  input  logic    bus,
  input  logic    rst_n,
  input  logic    ctl_rst,
  input  sample_t cfg_lvl,    // trigger level
  input  sample_t cfg_hst,    // hysteresis
  input  logic    cfg_edg,    // 0 pos, 1 neg
  input  logic    adc_valid,
  input  sample_t adc_data,
  output logic    edge_trg
);

  // one extra bit so level +/- hysteresis cannot wrap
  logic signed [$bits(sample_t):0] lvl_x;
  logic signed [$bits(sample_t):0] smp_x;
  logic signed [$bits(sample_t):0] thr_lo;  // arm point, pos edge
  logic signed [$bits(sample_t):0] thr_hi;  // arm point, neg edge
  logic armed;
  logic do_arm;
  logic do_fire;

  assign lvl_x  = cfg_lvl;   // sign extended
  assign smp_x  = adc_data;
  assign thr_lo = lvl_x - cfg_hst;
  assign thr_hi = lvl_x + cfg_hst;

  always_comb begin
    if (!cfg_edg) begin
      do_arm  = smp_x < thr_lo;            // well below level
      do_fire = armed && (smp_x >= lvl_x); // crossed upward
    end else begin
      do_arm  = smp_x > thr_hi;            // mirror for falling
      do_fire = armed && (smp_x <= lvl_x);
    end
  end

  always_ff @(posedge bus) begin
    if (!rst_n || ctl_rst) begin
      armed    <= 1'b0;
      edge_trg <= 1'b0;
    end else begin
      edge_trg <= adc_valid && do_fire;
      if (adc_valid) begin
        if (do_fire) armed <= 1'b0;       // disarm after firing
        else if (do_arm) armed <= 1'b1;
      end
    end
  end

  // re-arm takes at least one more sample
  a_trg_pulse: assert property (@(posedge bus) disable iff (!rst_n)
    edge_trg |=> !edge_trg);

endmodule : scope_edge

/* source/scope_decimator.sv */
/*
 * scope decimator
 * keeps one sample per group, or the shifted group sum when averaging
 */
`timescale 1ns/1ps

module scope_decimator import scope_pkg::*; (
  input  logic    bus,
  input  logic    rst_n,
  input  logic    ctl_rst,    // restart group
  input  logic    cfg_avg,    // averaging enable
  input  dec_t    cfg_dec,    // group size, 0 and 1 bypass
  input  shr_t    cfg_shr,    // sum shift right
  input  logic    adc_valid,
  input  sample_t adc_data,
  output logic    dec_valid,
  output sample_t dec_data
);

  dec_t cnt;      // samples so far in group
  acc_t acc;      // running group sum
  acc_t acc_sum;  // sum including current sample
  logic grp_end;  // current sample closes the group

  assign acc_sum = acc + acc_t'(adc_data);  // sign extended add
  // >= so a factor lowered mid group still closes it
  assign grp_end = (cfg_dec <= dec_t'(1)) || (cnt >= cfg_dec - dec_t'(1));

  //////////////////////////////////////////////////
  // group counter and accumulator
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n || ctl_rst) begin
      cnt       <= '0;
      acc       <= '0;
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= adc_valid && grp_end;
      if (adc_valid) begin
        if (grp_end) begin
          cnt <= '0;  // next sample starts a fresh group
          acc <= '0;
        end else begin
          cnt <= cnt + dec_t'(1);
          acc <= acc_sum;
        end
      end
    end
  end

  // output sample, last of group or shifted sum truncated to sample width
  always_ff @(posedge bus) begin
    if (adc_valid && grp_end) begin
      dec_data <= cfg_avg ? sample_t'(acc_sum >>> cfg_shr) : adc_data;
    end
  end

endmodule : scope_decimator

/* source/scope_regs.sv */
/*
 * scope register block
 * axi4-lite slave with configuration, control pulses and status readback
 */
`timescale 1ns/1ps

module scope_regs import scope_pkg::*; (
  input  logic      bus,
  input  logic      rst_n,
  // axi4-lite slave
  input  reg_addr_t s_awaddr,
  input  logic      s_awvalid,
  output logic      s_awready,
  input  reg_data_t s_wdata,
  input  logic [3:0] s_wstrb,
  input  logic      s_wvalid,
  output logic      s_wready,
  output logic [1:0] s_bresp,
  output logic      s_bvalid,
  input  logic      s_bready,
  input  reg_addr_t s_araddr,
  input  logic      s_arvalid,
  output logic      s_arready,
  output reg_data_t s_rdata,
  output logic [1:0] s_rresp,
  output logic      s_rvalid,
  input  logic      s_rready,
  // status from acquisition
  input  logic      sts_acq,
  input  logic      sts_trg,
  input  cnt_t      sts_pre,
  input  cnt_t      sts_pst,
  // control pulses
  output logic      ctl_rst,
  output logic      ctl_trg,
  output logic      ctl_acq,
  output logic      ctl_stp,
  // configuration
  output cnt_t      cfg_pre,
  output cnt_t      cfg_pst,
  output sample_t   cfg_lvl,
  output sample_t   cfg_hst,
  output logic      cfg_edg,
  output logic      cfg_avg,
  output dec_t      cfg_dec,
  output shr_t      cfg_shr
);

  logic      wr_hs;    // aw and w accepted this cycle
  logic      rd_hs;    // ar accepted this cycle
  reg_data_t rd_data;  // read mux
  logic [1:0] rd_resp;

  // byte lane merge of new write data into old register value
  function automatic reg_data_t strb_merge(reg_data_t old_v, reg_data_t new_v,
                                           logic [3:0] strb);
    reg_data_t res;
    for (int i = 0; i < 4; i++) begin
      res[8*i +: 8] = strb[i] ? new_v[8*i +: 8] : old_v[8*i +: 8];
    end
    return res;
  endfunction

  assign wr_hs = s_awvalid && s_awready && s_wvalid && s_wready;
  assign rd_hs = s_arvalid && s_arready;

  //////////////////////////////////////////////////
  // write channel
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      s_awready <= 1'b0;
      s_wready  <= 1'b0;
      s_bvalid  <= 1'b0;
      {ctl_rst, ctl_trg, ctl_acq, ctl_stp} <= '0;
      cfg_pre <= '0;
      cfg_pst <= '0;
      cfg_lvl <= '0;
      cfg_hst <= '0;
      cfg_edg <= 1'b0;
      cfg_avg <= 1'b0;
      cfg_dec <= '0;
      cfg_shr <= '0;
    end else begin
      // single cycle ready, only with both channels valid and no pending b
      s_awready <= s_awvalid && s_wvalid && !s_bvalid && !s_awready;
      s_wready  <= s_awvalid && s_wvalid && !s_bvalid && !s_awready;
      {ctl_rst, ctl_trg, ctl_acq, ctl_stp} <= '0;  // pulses by default
      if (s_bvalid && s_bready) s_bvalid <= 1'b0;
      if (wr_hs) begin
        s_bvalid <= 1'b1;
        s_bresp  <= RESP_OKAY;
        case (s_awaddr)
          REG_CTL: if (s_wstrb[0]) begin
            ctl_rst <= s_wdata[0];
            ctl_trg <= s_wdata[1];
            ctl_acq <= s_wdata[2];
            ctl_stp <= s_wdata[3];
          end
          REG_PRE: cfg_pre <= strb_merge(cfg_pre, s_wdata, s_wstrb);
          REG_PST: cfg_pst <= strb_merge(cfg_pst, s_wdata, s_wstrb);
          REG_LVL: cfg_lvl <= sample_t'(strb_merge(reg_data_t'(cfg_lvl), s_wdata, s_wstrb));
          REG_HST: cfg_hst <= sample_t'(strb_merge(reg_data_t'(cfg_hst), s_wdata, s_wstrb));
          REG_EDG: if (s_wstrb[0]) cfg_edg <= s_wdata[0];
          REG_AVG: if (s_wstrb[0]) cfg_avg <= s_wdata[0];
          REG_DEC: cfg_dec <= dec_t'(strb_merge(reg_data_t'(cfg_dec), s_wdata, s_wstrb));
          REG_SHR: if (s_wstrb[0]) cfg_shr <= s_wdata[3:0];
          default: s_bresp <= RESP_SLVERR;  // read-only or unmapped
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // read channel
  //////////////////////////////////////////////////

  always_comb begin
    rd_resp = RESP_OKAY;
    case (s_araddr)
      REG_CTL:     rd_data = '0;  // write only, reads as zero
      REG_STS:     rd_data = {30'd0, sts_trg, sts_acq};
      REG_PRE:     rd_data = cfg_pre;
      REG_PST:     rd_data = cfg_pst;
      REG_STS_PRE: rd_data = sts_pre;
      REG_STS_PST: rd_data = sts_pst;
      REG_LVL:     rd_data = reg_data_t'(cfg_lvl);  // sign extended
      REG_HST:     rd_data = reg_data_t'(cfg_hst);
      REG_EDG:     rd_data = {31'd0, cfg_edg};
      REG_AVG:     rd_data = {31'd0, cfg_avg};
      REG_DEC:     rd_data = reg_data_t'(cfg_dec);
      REG_SHR:     rd_data = reg_data_t'(cfg_shr);
      default: begin
        rd_data = '0;
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      s_arready <= 1'b0;
      s_rvalid  <= 1'b0;
    end else begin
      s_arready <= s_arvalid && !s_rvalid && !s_arready;
      if (s_rvalid && s_rready) s_rvalid <= 1'b0;
      if (rd_hs) s_rvalid <= 1'b1;
    end
  end

  // response payload, held while rvalid waits
  always_ff @(posedge bus) begin
    if (rd_hs) begin
      s_rdata <= rd_data;
      s_rresp <= rd_resp;
    end
  end

  // write response must wait for the master
  a_bvalid_hold: assert property (@(posedge bus) disable iff (!rst_n)
    s_bvalid && !s_bready |=> s_bvalid);

endmodule : scope_regs

/* source/scope_pkg.sv */
/*
 * scope channel package
 * sample, counter and bus types, register map and acquisition states
 */
package scope_pkg;

  //////////////////////////////////////////////////
  // data types
  //////////////////////////////////////////////////

  typedef logic signed [14-1:0] sample_t;    // raw adc sample
  typedef logic        [17-1:0] dec_t;       // decimation factor
  typedef logic        [ 4-1:0] shr_t;       // right shift after averaging
  typedef logic signed [31-1:0] acc_t;       // sample + factor width, no overflow
  typedef logic        [32-1:0] cnt_t;       // pre/post trigger counters

  typedef logic        [ 7-1:0] reg_addr_t;  // axi4-lite byte address
  typedef logic        [32-1:0] reg_data_t;  // axi4-lite data word

  //////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////

  localparam reg_addr_t REG_CTL     = 7'h00;  // wo: rst, trg, start, stop
  localparam reg_addr_t REG_STS     = 7'h04;  // ro: acquiring, triggered
  localparam reg_addr_t REG_PRE     = 7'h10;
  localparam reg_addr_t REG_PST     = 7'h14;
  localparam reg_addr_t REG_STS_PRE = 7'h18;  // ro
  localparam reg_addr_t REG_STS_PST = 7'h1C;  // ro
  localparam reg_addr_t REG_LVL     = 7'h50;
  localparam reg_addr_t REG_HST     = 7'h54;
  localparam reg_addr_t REG_EDG     = 7'h58;  // 0 pos, 1 neg
  localparam reg_addr_t REG_AVG     = 7'h60;
  localparam reg_addr_t REG_DEC     = 7'h64;
  localparam reg_addr_t REG_SHR     = 7'h68;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  //////////////////////////////////////////////////
  // acquisition fsm
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ACQ_IDLE,   // waiting for start
    ACQ_PRE,    // collecting pre-trigger samples
    ACQ_ARMED,  // trigger accepted here
    ACQ_POST    // collecting post-trigger samples
  } acq_state_t;

endpackage : scope_pkg
